/* logic/load_forward.sv */
`timescale 1ns/1ps
`default_nettype none

module load_forward import lsq_pkg::*; #(
    parameter int depth = 8
) (
    input  lsq_entry_t [depth-1:0]       entries,
    input  wire logic [$clog2(depth)-1:0] head,
    output load_result_t                  result,
    output lsq_entry_t                    load_req
);

    localparam int ptr_w = $clog2(depth);
    typedef logic [ptr_w-1:0] ptr_t;

    logic       found;
    ptr_t       ld_off;
    lsq_entry_t ld;
    logic       must_wait;
    logic       decided;
    logic       fwd;
    xlen_t      fwd_data;
    logic       fwd_valid;
    logic       mem_req;

    // oldest issued load, counted as an offset from head
    always_comb begin
        ptr_t idx;
        found  = 1'b0;
        ld_off = '0;
        ld     = '0;
        for (int k = 0; k < depth; k++) begin
            idx = head + ptr_t'(k);
            if (!found && entries[idx].valid && entries[idx].issued
                && !entries[idx].is_store) begin
                found  = 1'b1;
                ld_off = ptr_t'(k);
                ld     = entries[idx];
            end
        end
    end

    // older entries, youngest first
    always_comb begin
        ptr_t        idx;
        logic [32:0] s_end;
        logic [32:0] l_end;
        logic [1:0]  byte_off;
        xlen_t       shifted;
        idx       = '0;
        s_end     = '0;
        byte_off  = '0;
        shifted   = '0;
        must_wait = 1'b0;
        decided   = 1'b0;
        fwd       = 1'b0;
        fwd_data  = '0;
        l_end     = {1'b0, ld.addr} + ((ld.func3 == f3_word) ? 33'd4 : 33'd1);
        for (int k = depth - 1; k >= 0; k--) begin
            idx = head + ptr_t'(k);
            if (found && k < int'(ld_off)) begin
                if (!entries[idx].issued) begin
                    must_wait = 1'b1;
                end else if (entries[idx].is_store && !decided) begin
                    s_end = {1'b0, entries[idx].addr}
                            + (entries[idx].half ? 33'd2 : 33'd4);
                    if ({1'b0, ld.addr} < s_end && {1'b0, entries[idx].addr} < l_end) begin
                        decided = 1'b1;
                        if (ld.func3 == f3_word && !entries[idx].half
                            && ld.addr == entries[idx].addr) begin
                            fwd      = 1'b1;
                            fwd_data = entries[idx].data;
                        end else if (ld.func3 == f3_byte_u) begin
                            // a one-byte load that overlaps always sits inside the store
                            byte_off = ld.addr[1:0] - entries[idx].addr[1:0];
                            shifted  = entries[idx].data >> {byte_off, 3'b000};
                            fwd      = 1'b1;
                            fwd_data = {24'b0, shifted[7:0]};
                        end
                    end
                end
            end
        end
    end

    // an unissued older entry overrides both forward and memory
    assign fwd_valid = found && !must_wait && fwd;
    assign mem_req   = found && !must_wait && !decided;

    assign result.fwd_valid = fwd_valid;
    assign result.fwd_data  = fwd_valid ? fwd_data : '0;
    assign result.mem_req   = mem_req;
    assign result.rob_tag   = found ? ld.rob_tag : '0;
    assign result.pd        = found ? ld.pd : '0;

    assign load_req = mem_req ? ld : '0;

endmodule

`default_nettype wire

/* logic/lsq_pkg.sv */
`default_nettype none

package lsq_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  rob_tag_t;
    typedef logic [6:0]  preg_t;

    // memory opcodes
    localparam logic [6:0] opcode_load  = 7'b0000011;
    localparam logic [6:0] opcode_store = 7'b0100011;

    // access size codes
    localparam logic [2:0] f3_word   = 3'b010;
    localparam logic [2:0] f3_half   = 3'b001;
    localparam logic [2:0] f3_byte_u = 3'b100;

    // dispatch reserves a slot in program order
    typedef struct packed {
        rob_tag_t rob_tag;
        xlen_t    pc;
    } dispatch_t;

    // operands arrive here once the memory op leaves its reservation station
    typedef struct packed {
        rob_tag_t   rob_tag;
        xlen_t      pc;
        preg_t      pd;
        logic       is_store;
        logic [2:0] func3;
        xlen_t      base;
        xlen_t      imm;
        xlen_t      store_data;
    } issue_t;

    typedef struct packed {
        logic       valid;
        logic       issued;
        logic       is_store;
        logic       half;
        logic [2:0] func3;
        rob_tag_t   rob_tag;
        preg_t      pd;
        xlen_t      pc;
        xlen_t      addr;
        xlen_t      data;
    } lsq_entry_t;

    typedef struct packed {
        logic     fwd_valid;
        xlen_t    fwd_data;
        logic     mem_req;
        rob_tag_t rob_tag;
        preg_t    pd;
    } load_result_t;

endpackage

`default_nettype wire

/* logic/lsq_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module lsq_queue import lsq_pkg::*; #(
    parameter int depth = 8
) (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       dispatch_valid,
    input  dispatch_t                       dispatch,
    input  wire logic                       issued,
    input  issue_t                          issue,
    input  wire logic                       retired,
    input  rob_tag_t                        rob_head,
    input  wire logic                       mispredict,
    input  xlen_t                           mispredict_pc,
    output lsq_entry_t [depth-1:0]          entries,
    output logic [$clog2(depth)-1:0]        head,
    output logic                            full,
    output logic                            store_done,
    output rob_tag_t                        store_rob_tag,
    output logic                            store_wb,
    output lsq_entry_t                      store_out
);

    localparam int ptr_w = $clog2(depth);
    typedef logic [ptr_w-1:0] ptr_t;

    lsq_entry_t [depth-1:0] ent_q;
    ptr_t                   wr_ptr;
    ptr_t                   rd_ptr;
    ptr_t                   flush_wr_ptr;
    logic [depth-1:0]       flush_mask;
    logic [depth-1:0]       issue_hit;
    lsq_entry_t             head_ent;
    logic                   dispatch_ok;
    logic                   issue_ok;
    logic                   retire_ok;

    assign head_ent = ent_q[rd_ptr];

    // next slot still occupied means every slot is taken
    assign full = ent_q[wr_ptr].valid;

    assign dispatch_ok = dispatch_valid && !full && !mispredict;
    assign issue_ok    = issued && (!mispredict || issue.pc < mispredict_pc);
    assign retire_ok   = retired && head_ent.valid && head_ent.issued
                         && head_ent.rob_tag == rob_head;

    always_comb begin
        for (int i = 0; i < depth; i++) begin
            issue_hit[i] = issue_ok && ent_q[i].valid && !ent_q[i].issued
                           && ent_q[i].rob_tag == issue.rob_tag;
        end
    end

    // walk back from the tail, stop at the first entry that survives
    always_comb begin
        ptr_t idx;
        logic stop;
        flush_mask   = '0;
        flush_wr_ptr = wr_ptr;
        stop         = 1'b0;
        for (int k = 0; k < depth; k++) begin
            idx = flush_wr_ptr - 1'b1;
            if (!stop && ent_q[idx].valid && ent_q[idx].pc >= mispredict_pc
                && !(retire_ok && idx == rd_ptr)) begin
                flush_mask[idx] = 1'b1;
                flush_wr_ptr    = idx;
            end else begin
                stop = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ent_q         <= '0;
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            store_done    <= 1'b0;
            store_rob_tag <= '0;
            store_wb      <= 1'b0;
            store_out     <= '0;
        end else begin
            store_done <= (|issue_hit) && issue.is_store;
            store_wb   <= retire_ok && head_ent.is_store;

            if ((|issue_hit) && issue.is_store) begin
                store_rob_tag <= issue.rob_tag;
            end
            if (retire_ok) begin
                store_out <= head_ent;
            end

            // allocate in program order
            if (dispatch_ok) begin
                ent_q[wr_ptr] <= '{valid: 1'b1, rob_tag: dispatch.rob_tag,
                                   pc: dispatch.pc, default: '0};
                wr_ptr        <= wr_ptr + 1'b1;
            end

            // fill operands and effective address
            for (int i = 0; i < depth; i++) begin
                if (issue_hit[i]) begin
                    ent_q[i].issued   <= 1'b1;
                    ent_q[i].is_store <= issue.is_store;
                    ent_q[i].half     <= issue.is_store && issue.func3 == f3_half;
                    ent_q[i].func3    <= issue.func3;
                    ent_q[i].pd       <= issue.pd;
                    ent_q[i].addr     <= issue.base + issue.imm;
                    ent_q[i].data     <= issue.store_data;
                end
            end

            if (retire_ok) begin
                ent_q[rd_ptr].valid  <= 1'b0;
                ent_q[rd_ptr].issued <= 1'b0;
                rd_ptr               <= rd_ptr + 1'b1;
            end

            // flush comes last so it overrides a same-cycle fill
            if (mispredict) begin
                for (int i = 0; i < depth; i++) begin
                    if (flush_mask[i]) begin
                        ent_q[i] <= '0;
                    end
                end
                wr_ptr <= flush_wr_ptr;
            end
        end
    end

    assign entries = ent_q;
    assign head    = rd_ptr;

endmodule

`default_nettype wire

/* logic/lsq_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsq_top import lsq_pkg::*; #(
    parameter int depth = 8
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic dispatch_valid,
    input  dispatch_t dispatch,
    input  wire logic issued,
    input  issue_t    issue,
    input  wire logic retired,
    input  rob_tag_t  rob_head,
    input  wire logic mispredict,
    input  xlen_t     mispredict_pc,
    output logic      full,
    output logic      store_done,
    output rob_tag_t  store_rob_tag,
    output logic      store_wb,
    output lsq_entry_t store_out,
    output logic      load_forward_valid,
    output logic      load_mem,
    output xlen_t     load_forward_data,
    output preg_t     forward_load_pd,
    output rob_tag_t  forward_rob_index,
    output lsq_entry_t load_req
);

    lsq_entry_t [depth-1:0]   entries;
    logic [$clog2(depth)-1:0] head;
    load_result_t             result;

    lsq_queue #(.depth(depth)) u_queue (
        .clk           (clk),
        .reset         (reset),
        .dispatch_valid(dispatch_valid),
        .dispatch      (dispatch),
        .issued        (issued),
        .issue         (issue),
        .retired       (retired),
        .rob_head      (rob_head),
        .mispredict    (mispredict),
        .mispredict_pc (mispredict_pc),
        .entries       (entries),
        .head          (head),
        .full          (full),
        .store_done    (store_done),
        .store_rob_tag (store_rob_tag),
        .store_wb      (store_wb),
        .store_out     (store_out)
    );

    load_forward #(.depth(depth)) u_forward (
        .entries (entries),
        .head    (head),
        .result  (result),
        .load_req(load_req)
    );

    // resolver outcome onto the flat load ports
    assign load_forward_valid = result.fwd_valid;
    assign load_forward_data  = result.fwd_data;
    assign load_mem           = result.mem_req;
    assign forward_load_pd    = result.pd;
    assign forward_rob_index  = result.rob_tag;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -f src.f --top-module lsq_tb -o lsq_sim

./obj_dir/lsq_sim | tee sim.log

if grep -q "RESULT: FAIL" sim.log || ! grep -q "RESULT: PASS" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

/* src.f */
logic/lsq_pkg.sv
logic/lsq_queue.sv
logic/load_forward.sv
logic/lsq_top.sv
verif/lsq_props.sv
verif/lsq_tb.sv

/* verif/lsq_patterns.txt */
# op tag pc pd is_store func3 base imm data | full fv fdata mem ltag laddr pulse saddr
# all fields hex; retire lines give the expected store data in the data column
dispatch 00 100 0 0 0 0 0 0 0 0 0 0 0 0 0 0
dispatch 01 104 0 0 0 0 0 0 0 0 0 0 0 0 0 0
dispatch 02 108 0 0 0 0 0 0 0 0 0 0 0 0 0 0
dispatch 03 10c 0 0 0 0 0 0 0 0 0 0 0 0 0 0
dispatch 04 110 0 0 0 0 0 0 0 0 0 0 0 0 0 0
dispatch 05 114 0 0 0 0 0 0 0 0 0 0 0 0 0 0
dispatch 06 118 0 0 0 0 0 0 0 0 0 0 0 0 0 0
dispatch 07 11c 0 0 0 0 0 0 1 0 0 0 0 0 0 0
issue 00 100 01 1 2 1000 10 aabbccdd 1 0 0 0 0 0 1 0
retire 00 0 0 0 0 0 0 aabbccdd 0 0 0 0 0 0 1 1010
issue 01 104 02 1 2 2000 0 11223344 0 0 0 0 0 0 1 0
issue 02 108 05 0 2 2000 0 0 0 1 11223344 0 0 0 0 0
retire 01 0 0 0 0 0 0 11223344 0 0 0 1 02 2000 1 2000
retire 02 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
issue 03 10c 03 1 2 3000 4 deadbeef 0 0 0 0 0 0 1 0
issue 04 110 04 0 4 3000 6 0 0 1 ad 0 0 0 0 0
retire 03 0 0 0 0 0 0 deadbeef 0 0 0 1 04 3006 1 3004
retire 04 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
issue 06 118 07 0 2 4000 0 0 0 0 0 0 0 0 0 0
issue 05 114 06 1 1 4002 0 5555 0 0 0 0 0 0 1 0
retire 05 0 0 0 0 0 0 5555 0 0 0 1 06 4000 1 4002
retire 06 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
issue 07 11c 08 1 2 5000 0 77 0 0 0 0 0 0 1 0
retire 07 0 0 0 0 0 0 77 0 0 0 0 0 0 1 5000
dispatch 08 200 0 0 0 0 0 0 0 0 0 0 0 0 0 0
dispatch 09 204 0 0 0 0 0 0 0 0 0 0 0 0 0 0
dispatch 0a 208 0 0 0 0 0 0 0 0 0 0 0 0 0 0
mispredict 00 204 0 0 0 0 0 0 0 0 0 0 0 0 0 0
issue 09 204 09 1 2 7000 0 99 0 0 0 0 0 0 0 0
dispatch 0b 20c 0 0 0 0 0 0 0 0 0 0 0 0 0 0
dispatch 0c 210 0 0 0 0 0 0 0 0 0 0 0 0 0 0
dispatch 0d 214 0 0 0 0 0 0 0 0 0 0 0 0 0 0
dispatch 0e 218 0 0 0 0 0 0 0 0 0 0 0 0 0 0
dispatch 0f 21c 0 0 0 0 0 0 0 0 0 0 0 0 0 0
dispatch 10 220 0 0 0 0 0 0 0 0 0 0 0 0 0 0
dispatch 11 224 0 0 0 0 0 0 1 0 0 0 0 0 0 0
issue 08 200 0a 1 2 6000 0 88 1 0 0 0 0 0 1 0
retire 08 0 0 0 0 0 0 88 0 0 0 0 0 0 1 6000

/* verif/lsq_props.sv */
`timescale 1ns/1ps
`default_nettype none

module lsq_props (
    input wire logic clk,
    input wire logic reset,
    input wire logic dispatch_valid,
    input wire logic mispredict,
    input wire logic full,
    input wire logic retired,
    input wire logic store_done,
    input wire logic store_wb
);

    // both pulses start low once reset lets go
    assert property (@(posedge clk) $fell(reset) |-> !store_wb && !store_done)
        else $error("store pulse in first cycle after reset");

    // the sender never dispatches into a full queue
    assert property (@(posedge clk) disable iff (reset)
        dispatch_valid && !mispredict |-> !full)
        else $error("dispatch while queue full");

    // writeback only follows a retire strobe
    assert property (@(posedge clk) disable iff (reset)
        store_wb |-> $past(retired))
        else $error("store writeback without retire");

endmodule

bind lsq_queue lsq_props u_props (
    .clk           (clk),
    .reset         (reset),
    .dispatch_valid(dispatch_valid),
    .mispredict    (mispredict),
    .full          (full),
    .retired       (retired),
    .store_done    (store_done),
    .store_wb      (store_wb)
);

`default_nettype wire

/* verif/lsq_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lsq_tb import lsq_pkg::*; ();

    logic       clk;
    logic       reset;
    logic       dispatch_valid;
    dispatch_t  dispatch;
    logic       issued;
    issue_t     issue;
    logic       retired;
    rob_tag_t   rob_head;
    logic       mispredict;
    xlen_t      mispredict_pc;
    logic       full;
    logic       store_done;
    rob_tag_t   store_rob_tag;
    logic       store_wb;
    lsq_entry_t store_out;
    logic       load_forward_valid;
    logic       load_mem;
    xlen_t      load_forward_data;
    preg_t      forward_load_pd;
    rob_tag_t   forward_rob_index;
    lsq_entry_t load_req;

    integer errors;

    lsq_top #(.depth(8)) UUT (
        .clk               (clk),
        .reset             (reset),
        .dispatch_valid    (dispatch_valid),
        .dispatch          (dispatch),
        .issued            (issued),
        .issue             (issue),
        .retired           (retired),
        .rob_head          (rob_head),
        .mispredict        (mispredict),
        .mispredict_pc     (mispredict_pc),
        .full              (full),
        .store_done        (store_done),
        .store_rob_tag     (store_rob_tag),
        .store_wb          (store_wb),
        .store_out         (store_out),
        .load_forward_valid(load_forward_valid),
        .load_mem          (load_mem),
        .load_forward_data (load_forward_data),
        .forward_load_pd   (forward_load_pd),
        .forward_rob_index (forward_rob_index),
        .load_req          (load_req)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // wait for a store pulse, bounded to 20 cycles
    task automatic await_pulse(input logic wb, output logic seen);
        int cnt;
        cnt = 0;
        seen = wb ? store_wb : store_done;
        while (!seen && cnt < 20) begin
            @(negedge clk);
            cnt++;
            seen = wb ? store_wb : store_done;
        end
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        logic [95:0] op;
        logic [31:0] tag, pc, pd, st, f3, base, imm, data;
        logic [31:0] e_full, e_fv, e_fdata, e_mem, e_ltag, e_laddr, e_pulse, e_saddr;
        logic        seen;
        // destination register of each issued op, by rob tag
        preg_t       pd_by_tag [32];
        errors         = 0;
        void'($urandom(32'hbde3));
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        issued         = 1'b0;
        issue          = '0;
        retired        = 1'b0;
        rob_head       = '0;
        mispredict     = 1'b0;
        mispredict_pc  = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        compare("full", 0, 32'(full));
        compare("store_wb", 0, 32'(store_wb));
        compare("load_forward_valid", 0, 32'(load_forward_valid));

        fd = $fopen("verif/lsq_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open pattern file");
            $display("RESULT: FAIL");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() == 0 || line.getc(0) == 8'h23) begin
                    continue;
                end
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            op, tag, pc, pd, st, f3, base, imm, data,
                            e_full, e_fv, e_fdata, e_mem, e_ltag, e_laddr, e_pulse, e_saddr);
                if (n != 17) begin
                    continue;
                end
                // a few idle cycles between steps
                repeat ($urandom % 3) @(posedge clk);
                @(posedge clk);
                if (op == "dispatch") begin
                    dispatch_valid   <= 1'b1;
                    dispatch.rob_tag <= tag[4:0];
                    dispatch.pc      <= pc;
                end else if (op == "issue") begin
                    pd_by_tag[tag[4:0]] = pd[6:0];
                    issued           <= 1'b1;
                    issue.rob_tag    <= tag[4:0];
                    issue.pc         <= pc;
                    issue.pd         <= pd[6:0];
                    issue.is_store   <= st[0];
                    issue.func3      <= f3[2:0];
                    issue.base       <= base;
                    issue.imm        <= imm;
                    issue.store_data <= data;
                end else if (op == "retire") begin
                    retired  <= 1'b1;
                    rob_head <= tag[4:0];
                end else if (op == "mispredict") begin
                    mispredict    <= 1'b1;
                    mispredict_pc <= pc;
                end
                @(posedge clk);
                dispatch_valid <= 1'b0;
                issued         <= 1'b0;
                retired        <= 1'b0;
                mispredict     <= 1'b0;
                @(negedge clk);
                compare("full", e_full, 32'(full));
                compare("load_forward_valid", e_fv, 32'(load_forward_valid));
                compare("load_forward_data", e_fdata, load_forward_data);
                compare("load_mem", e_mem, 32'(load_mem));
                if (e_mem[0]) begin
                    compare("load_req.rob_tag", e_ltag, 32'(load_req.rob_tag));
                    compare("load_req.addr", e_laddr, load_req.addr);
                    compare("forward_rob_index", e_ltag, 32'(forward_rob_index));
                    compare("forward_load_pd", 32'(pd_by_tag[e_ltag[4:0]]),
                            32'(forward_load_pd));
                end
                if (op == "issue") begin
                    if (e_pulse[0]) begin
                        await_pulse(1'b0, seen);
                        if (!seen) begin
                            errors++;
                            $display("store_done never rose for rob tag %0h", tag);
                        end else begin
                            compare("store_rob_tag", tag, 32'(store_rob_tag));
                        end
                    end else if (store_done) begin
                        errors++;
                        $display("store_done rose for a flushed store at %0t", $time);
                    end
                end
                if (op == "retire") begin
                    if (e_pulse[0]) begin
                        await_pulse(1'b1, seen);
                        if (!seen) begin
                            errors++;
                            $display("store_wb never rose for rob tag %0h", tag);
                        end else begin
                            compare("store_out.addr", e_saddr, store_out.addr);
                            compare("store_out.data", data, store_out.data);
                        end
                    end else if (store_wb) begin
                        errors++;
                        $display("store_wb rose on a load retire at %0t", $time);
                    end
                end
            end
            $fclose(fd);

            $display("errors: %0d", errors);
            if (errors == 0) begin
                $display("RESULT: PASS");
            end else begin
                $display("RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire
